/* logic/video_pkg.sv */
package video_pkg;

	// One colour component as delivered by the core
	typedef logic [5:0] color_t;

	// One Y, Pb or Pr sample in 8-bit video range
	typedef logic [7:0] ycc_t;

	// Index into one half of the doubler line buffer
	typedef logic [6:0] line_addr_t;

	// Pixel with its syncs, sync pulses are positive
	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
		logic   hs;
		logic   vs;
	} pixel_t;

	// Amount of darkening applied to every second line
	typedef enum logic [1:0] {
		scan_none,
		scan_quarter,
		scan_half,
		scan_three_quarter
	} scan_level_t;

	// Longest line between hsync pulses, in pixel strobes
	localparam int LINE_LENGTH = 96;

	// OSD window placement and size
	localparam int OSD_X_OFFSET = 8;
	localparam int OSD_Y_OFFSET = 4;
	localparam int OSD_WIDTH    = 64;
	localparam int OSD_ROWS     = 8;

	// Bit 2 red, bit 1 green, bit 0 blue
	localparam logic [2:0] OSD_COLOR = 3'b100;

	// Command bytes of the OSD serial link
	localparam logic [7:0] OSD_CMD_ENABLE  = 8'h41;
	localparam logic [7:0] OSD_CMD_DISABLE = 8'h40;
	localparam logic [7:0] OSD_CMD_WRITE   = 8'h20;

endpackage

/* logic/scan_doubler.sv */
`timescale 1ns/100ps

module scan_doubler (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              ce_pix,
	input  video_pkg::pixel_t pix_in,
	input  logic              bypass,
	output video_pkg::pixel_t pix_out,
	output logic              pix_ce
);

	// Two line halves, one written while the other is replayed
	video_pkg::pixel_t line_buf [2][video_pkg::LINE_LENGTH];

	// Write side
	logic                  wr_half;
	video_pkg::line_addr_t wr_addr;
	logic                  hs_prev;
	logic                  swap;
	logic                  wr_sel;
	video_pkg::line_addr_t wr_idx;

	// Read side
	video_pkg::line_addr_t line_len;
	video_pkg::line_addr_t rd_addr;
	logic                  rd_active;
	logic                  rd_phase;
	logic                  rd_pass;
	logic                  rd_fire;

	// New line starts on the rising edge of input hsync
	assign swap = ce_pix && pix_in.hs && !hs_prev;

	// The pixel carrying the edge already belongs to the fresh half
	assign wr_sel = swap ? ~wr_half : wr_half;
	assign wr_idx = swap ? '0 : wr_addr;

	// One read every second cycle, twice the input pixel rate
	assign rd_fire = rd_active && rd_phase;

	always_ff @(posedge clk_sys) begin
		if (ce_pix)
			line_buf[wr_sel][wr_idx] <= pix_in;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_half  <= 1'b0;
			wr_addr  <= '0;
			hs_prev  <= 1'b0;
			line_len <= '0;
		end else if (ce_pix) begin
			hs_prev <= pix_in.hs;
			if (swap) begin
				wr_half  <= ~wr_half;
				wr_addr  <= video_pkg::line_addr_t'(1);
				// Length of the line just completed
				line_len <= wr_addr;
			end else begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_active <= 1'b0;
			rd_phase  <= 1'b0;
			rd_pass   <= 1'b0;
			rd_addr   <= '0;
		end else if (swap) begin
			// Nothing to replay before the first complete line
			rd_active <= (wr_addr != '0);
			rd_phase  <= 1'b0;
			rd_pass   <= 1'b0;
			rd_addr   <= '0;
		end else if (rd_active) begin
			rd_phase <= ~rd_phase;
			if (rd_fire) begin
				if (rd_addr == line_len - 1'b1) begin
					rd_addr <= '0;
					rd_pass <= 1'b1;
					// Second pass done, wait for the next swap
					if (rd_pass)
						rd_active <= 1'b0;
				end else begin
					rd_addr <= rd_addr + 1'b1;
				end
			end
		end
	end

	// Replayed pixels keep their own syncs, so hs shrinks with the rate
	always_ff @(posedge clk_sys) begin
		if (bypass) begin
			if (ce_pix)
				pix_out <= pix_in;
		end else if (rd_fire) begin
			pix_out <= line_buf[~wr_half][rd_addr];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			pix_ce <= 1'b0;
		else
			pix_ce <= bypass ? ce_pix : rd_fire;
	end

	// Core lines must fit one buffer half
	wr_addr_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		ce_pix |-> wr_idx < video_pkg::LINE_LENGTH);

endmodule

/* logic/scanline_dimmer.sv */
`timescale 1ns/100ps

module scanline_dimmer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  video_pkg::pixel_t      pix_in,
	input  logic                   pix_in_ce,
	input  video_pkg::scan_level_t level,
	output video_pkg::pixel_t      pix_out,
	output logic                   pix_ce
);

	logic hs_prev;
	logic vs_prev;
	logic toggle;
	logic toggle_next;

	// Scale one component by the selected amount
	function automatic video_pkg::color_t dim(input video_pkg::color_t c,
			input video_pkg::scan_level_t l);
		case (l)
			video_pkg::scan_quarter:       dim = (c >> 1) + (c >> 2);
			video_pkg::scan_half:          dim = c >> 1;
			video_pkg::scan_three_quarter: dim = c >> 2;
			default:                       dim = c;
		endcase
	endfunction

	// Flip on every hs fall, vs fall restarts the count
	always_comb begin
		toggle_next = toggle;
		if (hs_prev && !pix_in.hs)
			toggle_next = ~toggle_next;
		if (vs_prev && !pix_in.vs)
			toggle_next = 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs_prev <= 1'b0;
			vs_prev <= 1'b0;
			toggle  <= 1'b0;
			pix_ce  <= 1'b0;
		end else begin
			pix_ce <= pix_in_ce;
			if (pix_in_ce) begin
				hs_prev <= pix_in.hs;
				vs_prev <= pix_in.vs;
				toggle  <= toggle_next;
			end
		end
	end

	// Syncs pass untouched
	always_ff @(posedge clk_sys) begin
		if (pix_in_ce) begin
			pix_out    <= pix_in;
			if (toggle_next) begin
				pix_out.r <= dim(pix_in.r, level);
				pix_out.g <= dim(pix_in.g, level);
				pix_out.b <= dim(pix_in.b, level);
			end
		end
	end

endmodule

/* logic/osd_overlay.sv */
`timescale 1ns/100ps

module osd_overlay (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              spi_sck,
	input  logic              spi_ss,
	input  logic              spi_di,
	input  video_pkg::pixel_t pix_in,
	input  logic              pix_in_ce,
	output video_pkg::pixel_t pix_out,
	output logic              pix_ce
);

	// idle ignores bytes until ss rises, command takes the first byte
	typedef enum logic [1:0] {
		osd_idle,
		osd_command,
		osd_write
	} osd_state_t;

	osd_state_t state;
	logic [1:0] sck_d;
	logic       ss_q;
	logic       di_q;
	logic       sck_rise;
	logic [2:0] bit_cnt;
	logic [6:0] shift_reg;
	logic [7:0] rx_byte;
	logic       byte_done;
	logic [6:0] bm_addr;
	logic       osd_en;
	logic [7:0] bitmap [video_pkg::OSD_WIDTH];

	// Pixel position inside the frame
	logic [7:0] x_cnt;
	logic [7:0] y_cnt;
	logic [7:0] x_cur;
	logic [7:0] y_cur;
	logic [5:0] col;
	logic [2:0] row;
	logic       in_window;
	logic       lit;
	logic       hs_prev;
	logic       vs_prev;
	logic       hs_fall;
	logic       vs_fall;

	// Serial pins sampled in the system clock
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sck_d <= 2'b00;
			ss_q  <= 1'b1;
			di_q  <= 1'b0;
		end else begin
			sck_d <= {sck_d[0], spi_sck};
			ss_q  <= spi_ss;
			di_q  <= spi_di;
		end
	end

	assign sck_rise  = sck_d[0] && !sck_d[1];
	assign rx_byte   = {shift_reg, di_q};
	assign byte_done = sck_rise && !ss_q && (bit_cnt == 3'd7);

	// MSB first
	always_ff @(posedge clk_sys) begin
		if (sck_rise && !ss_q)
			shift_reg <= rx_byte[6:0];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= osd_idle;
			bit_cnt <= '0;
			bm_addr <= '0;
			osd_en  <= 1'b0;
		end else if (ss_q) begin
			state   <= osd_command;
			bit_cnt <= '0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 1'b1;
			if (byte_done) begin
				case (state)
					osd_command: begin
						state <= osd_idle;
						if (rx_byte == video_pkg::OSD_CMD_ENABLE)
							osd_en <= 1'b1;
						if (rx_byte == video_pkg::OSD_CMD_DISABLE)
							osd_en <= 1'b0;
						if (rx_byte == video_pkg::OSD_CMD_WRITE) begin
							state   <= osd_write;
							bm_addr <= '0;
						end
					end
					osd_write: bm_addr <= bm_addr + 1'b1;
					default:   state <= osd_idle;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_done && state == osd_write)
			bitmap[bm_addr[5:0]] <= rx_byte;
	end

	// Sync edges against the previous pixel
	assign hs_fall = hs_prev && !pix_in.hs;
	assign vs_fall = vs_prev && !pix_in.vs;

	// x restarts on hs fall, y counts hs falls and restarts on vs fall
	always_comb begin
		x_cur = x_cnt;
		y_cur = y_cnt;
		if (hs_fall) begin
			x_cur = '0;
			y_cur = y_cnt + 1'b1;
		end
		if (vs_fall)
			y_cur = '0;
	end

	assign col = 6'(x_cur - 8'(video_pkg::OSD_X_OFFSET));
	assign row = 3'(y_cur - 8'(video_pkg::OSD_Y_OFFSET));
	assign in_window = osd_en
		&& x_cur >= 8'(video_pkg::OSD_X_OFFSET)
		&& x_cur <  8'(video_pkg::OSD_X_OFFSET + video_pkg::OSD_WIDTH)
		&& y_cur >= 8'(video_pkg::OSD_Y_OFFSET)
		&& y_cur <  8'(video_pkg::OSD_Y_OFFSET + video_pkg::OSD_ROWS);
	// Bit 0 of each column byte is the top row
	assign lit = bitmap[col][row];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			x_cnt   <= '0;
			y_cnt   <= '0;
			hs_prev <= 1'b0;
			vs_prev <= 1'b0;
			pix_ce  <= 1'b0;
		end else begin
			pix_ce <= pix_in_ce;
			if (pix_in_ce) begin
				x_cnt   <= x_cur + 1'b1;
				y_cnt   <= y_cur;
				hs_prev <= pix_in.hs;
				vs_prev <= pix_in.vs;
			end
		end
	end

	// Lit bits draw the OSD colour, unlit bits shade the picture
	always_ff @(posedge clk_sys) begin
		if (pix_in_ce) begin
			pix_out <= pix_in;
			if (in_window && lit) begin
				pix_out.r <= video_pkg::OSD_COLOR[2] ? 6'd63 : 6'd0;
				pix_out.g <= video_pkg::OSD_COLOR[1] ? 6'd63 : 6'd0;
				pix_out.b <= video_pkg::OSD_COLOR[0] ? 6'd63 : 6'd0;
			end else if (in_window) begin
				pix_out.r <= pix_in.r >> 1;
				pix_out.g <= pix_in.g >> 1;
				pix_out.b <= pix_in.b >> 1;
			end
		end
	end

	// Host never writes past the end of the bitmap
	bitmap_addr_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		byte_done && state == osd_write |-> bm_addr < video_pkg::OSD_WIDTH);

endmodule

/* logic/ypbpr_encoder.sv */
`timescale 1ns/100ps

module ypbpr_encoder (
	input  logic              clk_sys,
	input  logic              reset,
	input  video_pkg::pixel_t pix_in,
	input  logic              pix_in_ce,
	input  logic              ypbpr,
	input  logic              ypbpr_full,
	input  logic              composite,
	output video_pkg::color_t vga_r,
	output video_pkg::color_t vga_g,
	output video_pkg::color_t vga_b,
	output logic              vga_hs,
	output logic              vga_vs,
	output logic              vga_ce
);

	// Fixed-point sums, 8 fraction bits
	logic [18:0]       y_sum;
	logic [18:0]       pb_sum;
	logic [18:0]       pr_sum;
	video_pkg::ycc_t   y;
	video_pkg::ycc_t   pb;
	video_pkg::ycc_t   pr;

	// Integer part limited to the video range
	function automatic video_pkg::ycc_t clamp(input logic [18:0] s, input logic [9:0] hi);
		if (s[17:8] < 10'd16)
			clamp = 8'd16;
		else if (s[17:8] > hi)
			clamp = hi[7:0];
		else
			clamp = s[15:8];
	endfunction

	// Limited range keeps the top bits, full range stretches 16..240 over 0..63
	function automatic video_pkg::color_t scale(input video_pkg::ycc_t v, input logic full);
		logic [11:0] prod;
		prod = 12'(v - 8'd16) * 12'd9;
		scale = full ? video_pkg::color_t'(prod >> 5) : v[7:2];
	endfunction

	assign y_sum  = 19'd4096 + 19'd264 * pix_in.r + 19'd516 * pix_in.g + 19'd100 * pix_in.b;
	assign pb_sum = 19'd32768 - 19'd152 * pix_in.r - 19'd296 * pix_in.g
		+ 19'd448 * pix_in.b;
	assign pr_sum = 19'd32768 + 19'd448 * pix_in.r - 19'd376 * pix_in.g
		- 19'd72 * pix_in.b;

	assign y  = clamp(y_sum, 10'd235);
	assign pb = clamp(pb_sum, 10'd240);
	assign pr = clamp(pr_sum, 10'd240);

	always_ff @(posedge clk_sys) begin
		if (pix_in_ce) begin
			// Pr on red, Y on green, Pb on blue
			vga_r <= ypbpr ? scale(pr, ypbpr_full) : pix_in.r;
			vga_g <= ypbpr ? scale(y, ypbpr_full)  : pix_in.g;
			vga_b <= ypbpr ? scale(pb, ypbpr_full) : pix_in.b;
		end
	end

	// Negative syncs, composite sync on hs for YPbPr and 15 kHz
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_ce <= 1'b0;
		end else begin
			vga_ce <= pix_in_ce;
			if (pix_in_ce) begin
				vga_hs <= (ypbpr || composite) ? ~(pix_in.hs ^ pix_in.vs) : ~pix_in.hs;
				vga_vs <= (ypbpr || composite) ? 1'b1 : ~pix_in.vs;
			end
		end
	end

	// Limited range output stays inside the clamped codes
	limited_range_out: assert property (@(posedge clk_sys) disable iff (reset)
		pix_in_ce && ypbpr && !ypbpr_full |=>
			vga_g inside {[6'd4:6'd58]} && vga_r inside {[6'd4:6'd60]}
			&& vga_b inside {[6'd4:6'd60]});

endmodule

/* logic/video_mixer.sv */
`timescale 1ns/100ps

module video_mixer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ce_pix,
	input  video_pkg::pixel_t      pix_in,
	input  video_pkg::scan_level_t scanlines,
	input  logic                   scandouble_off,
	input  logic                   ypbpr,
	input  logic                   ypbpr_full,
	input  logic                   spi_sck,
	input  logic                   spi_ss,
	input  logic                   spi_di,
	output video_pkg::color_t      vga_r,
	output video_pkg::color_t      vga_g,
	output video_pkg::color_t      vga_b,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output logic                   vga_ce
);

	// Stage outputs, each with its own strobe
	video_pkg::pixel_t sd_pix;
	logic              sd_ce;
	video_pkg::pixel_t dim_pix;
	logic              dim_ce;
	video_pkg::pixel_t osd_pix;
	logic              osd_ce;

	// 31 kHz doubling unless switched off
	scan_doubler u_scan_doubler (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_pix  (ce_pix),
		.pix_in  (pix_in),
		.bypass  (scandouble_off),
		.pix_out (sd_pix),
		.pix_ce  (sd_ce)
	);

	scanline_dimmer u_scanline_dimmer (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.pix_in    (sd_pix),
		.pix_in_ce (sd_ce),
		.level     (scanlines),
		.pix_out   (dim_pix),
		.pix_ce    (dim_ce)
	);

	osd_overlay u_osd_overlay (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.spi_sck   (spi_sck),
		.spi_ss    (spi_ss),
		.spi_di    (spi_di),
		.pix_in    (dim_pix),
		.pix_in_ce (dim_ce),
		.pix_out   (osd_pix),
		.pix_ce    (osd_ce)
	);

	// 15 kHz output always carries composite sync
	ypbpr_encoder u_ypbpr_encoder (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pix_in     (osd_pix),
		.pix_in_ce  (osd_ce),
		.ypbpr      (ypbpr),
		.ypbpr_full (ypbpr_full),
		.composite  (scandouble_off),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.vga_ce     (vga_ce)
	);

endmodule

/* dv/video_model.svh */
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

// Expected VGA pins for every vga_ce, syncs at pin level
video_pkg::pixel_t exp_q[$];

// Core line held back until the next hsync starts
video_pkg::pixel_t held_line[$];
logic              core_hs_prev;

// Sync history of the stream behind the doubler
logic              hs_prev;
logic              vs_prev;
logic              dim_line;
int                osd_x;
int                osd_y;

// Bitmap and enable as last loaded over the serial link
logic [7:0]        osd_bits [video_pkg::OSD_WIDTH];
logic              osd_on;

// Same state as the DUT right after reset
function automatic void clear_model();
	exp_q.delete();
	held_line.delete();
	core_hs_prev = 1'b0;
	hs_prev      = 1'b0;
	vs_prev      = 1'b0;
	dim_line     = 1'b0;
	osd_x        = 0;
	osd_y        = 0;
	osd_on       = 1'b0;
endfunction

// Share of the colour kept on a darkened line
function automatic video_pkg::color_t darken(input video_pkg::color_t c);
	int x;
	x = int'(c);
	case (scanlines)
		video_pkg::scan_quarter:       x = x / 2 + x / 4;
		video_pkg::scan_half:          x = x / 2;
		video_pkg::scan_three_quarter: x = x / 4;
		default: ;
	endcase
	return video_pkg::color_t'(x);
endfunction

// Integer part of a sum, held inside the video range
function automatic int to_range(input int sum, input int hi);
	int v;
	v = sum / 256;
	if (v < 16)
		v = 16;
	if (v > hi)
		v = hi;
	return v;
endfunction

// Six bit pin code of one Y, Pb or Pr sample
function automatic video_pkg::color_t pin_code(input int v);
	if (ypbpr_full)
		return video_pkg::color_t'((v - 16) * 9 / 32);
	return video_pkg::color_t'(v / 4);
endfunction

function automatic video_pkg::pixel_t encode(input video_pkg::pixel_t px);
	video_pkg::pixel_t o;
	int                r;
	int                g;
	int                b;
	logic              csync;
	r = int'(px.r);
	g = int'(px.g);
	b = int'(px.b);
	o = px;
	// Pr on red, Y on green, Pb on blue
	if (ypbpr) begin
		o.g = pin_code(to_range(4096 + 264 * r + 516 * g + 100 * b, 235));
		o.b = pin_code(to_range(32768 - 152 * r - 296 * g + 448 * b, 240));
		o.r = pin_code(to_range(32768 + 448 * r - 376 * g - 72 * b, 240));
	end
	// 15 kHz and YPbPr put composite sync on hs
	csync = ypbpr || scandouble_off;
	o.hs  = csync ? !(px.hs ^ px.vs) : !px.hs;
	o.vs  = csync ? 1'b1 : !px.vs;
	return o;
endfunction

function automatic video_pkg::pixel_t blend_osd(input video_pkg::pixel_t px, input int x,
		input int y);
	video_pkg::pixel_t o;
	int                col;
	int                row;
	o   = px;
	col = x - video_pkg::OSD_X_OFFSET;
	row = y - video_pkg::OSD_Y_OFFSET;
	if (!osd_on || col < 0 || col >= video_pkg::OSD_WIDTH)
		return o;
	if (row < 0 || row >= video_pkg::OSD_ROWS)
		return o;
	// Byte per column, bit 0 is the top row
	if (osd_bits[col][row]) begin
		o.r = video_pkg::OSD_COLOR[2] ? 6'd63 : 6'd0;
		o.g = video_pkg::OSD_COLOR[1] ? 6'd63 : 6'd0;
		o.b = video_pkg::OSD_COLOR[0] ? 6'd63 : 6'd0;
	end else begin
		o.r = px.r / 2;
		o.g = px.g / 2;
		o.b = px.b / 2;
	end
	return o;
endfunction

// Dimmer, OSD and encoder for one pixel leaving the doubler
function automatic void through_stages(input video_pkg::pixel_t px);
	video_pkg::pixel_t p;
	logic              hs_fall;
	logic              vs_fall;
	int                x;
	hs_fall = hs_prev && !px.hs;
	vs_fall = vs_prev && !px.vs;
	if (hs_fall)
		dim_line = !dim_line;
	if (vs_fall)
		dim_line = 1'b0;
	p = px;
	if (dim_line) begin
		p.r = darken(px.r);
		p.g = darken(px.g);
		p.b = darken(px.b);
	end
	// Window position, x from hs fall and y in hs falls since vs fall
	x = hs_fall ? 0 : osd_x;
	if (hs_fall)
		osd_y = (osd_y + 1) % 256;
	if (vs_fall)
		osd_y = 0;
	osd_x   = (x + 1) % 256;
	hs_prev = px.hs;
	vs_prev = px.vs;
	exp_q.push_back(encode(blend_osd(p, x, osd_y)));
endfunction

function automatic void feed_core_pixel(input video_pkg::pixel_t px);
	int pass;
	if (scandouble_off) begin
		through_stages(px);
	end else begin
		// A new line releases the previous one twice
		if (px.hs && !core_hs_prev) begin
			for (pass = 0; pass < 2; pass++)
				foreach (held_line[i])
					through_stages(held_line[i]);
			held_line.delete();
		end
		held_line.push_back(px);
	end
	core_hs_prev = px.hs;
endfunction

`endif

/* dv/video_mixer_tb.sv */
`timescale 1ns/100ps

module video_mixer_tb;

	// Core frame geometry
	localparam int PIX_CYCLES   = 4;
	localparam int LINES        = 12;
	localparam int LINE_PIXELS  = 80;
	localparam int HS_PIXELS    = 8;
	localparam int FRAME_CYCLES = LINES * LINE_PIXELS * PIX_CYCLES;
	// One frame per video test, two for the OSD
	localparam int TOTAL_FRAMES  = 9;
	// Bitmap, write, enable and disable bytes at 8 bits of 8 cycles, plus framing
	localparam int SERIAL_CYCLES = (video_pkg::OSD_WIDTH + 3) * 64 + 3 * 24;
	localparam int RESET_CYCLES  = 9 * 64;
	localparam int TIMEOUT = (TOTAL_FRAMES * FRAME_CYCLES + SERIAL_CYCLES + RESET_CYCLES) * 6 / 5;

	logic                   clk_sys;
	logic                   reset;
	logic                   ce_pix;
	video_pkg::pixel_t      pix_in;
	video_pkg::scan_level_t scanlines;
	logic                   scandouble_off;
	logic                   ypbpr;
	logic                   ypbpr_full;
	logic                   spi_sck;
	logic                   spi_ss;
	logic                   spi_di;
	video_pkg::color_t      vga_r;
	video_pkg::color_t      vga_g;
	video_pkg::color_t      vga_b;
	logic                   vga_hs;
	logic                   vga_vs;
	logic                   vga_ce;

	integer            seed = 32'hee57;
	int                cycle_count;
	int                error_count;
	int                test_start;
	int                tests_run;
	int                tests_failed;
	video_pkg::pixel_t got_q[$];

	`include "video_model.svh"

	video_mixer DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Outputs taken mid cycle, away from the driving edge
	always @(negedge clk_sys) begin
		if (vga_ce)
			got_q.push_back({vga_r, vga_g, vga_b, vga_hs, vga_vs});
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Run stopped by timeout after %0d cycles", cycle_count);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_value(input string name, input logic [7:0] got,
			input logic [7:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, expected);
		end
	endtask

	// Inputs move 10 ns after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic apply_reset();
		step();
		reset = 1'b1;
		repeat (16) step();
		reset = 1'b0;
		clear_model();
		got_q.delete();
	endtask

	// hs on the first 8 strobes of a line, vs over the whole first line
	task automatic send_frames(input int frames);
		video_pkg::pixel_t px;
		logic [31:0]       rnd;
		int                f;
		int                ln;
		int                p;
		for (f = 0; f < frames; f++)
			for (ln = 0; ln < LINES; ln++)
				for (p = 0; p < LINE_PIXELS; p++) begin
					rnd   = $random(seed);
					px.hs = (p < HS_PIXELS);
					px.vs = (ln == 0);
					px.r  = px.hs ? 6'd0 : rnd[5:0];
					px.g  = px.hs ? 6'd0 : rnd[11:6];
					px.b  = px.hs ? 6'd0 : rnd[17:12];
					step();
					ce_pix = 1'b1;
					pix_in = px;
					feed_core_pixel(px);
					step();
					ce_pix = 1'b0;
					repeat (PIX_CYCLES - 2) step();
				end
	endtask

	// Mode 0 serial, bit on di while sck is low, taken on the rise
	task automatic send_serial_byte(input logic [7:0] b);
		int i;
		for (i = 7; i >= 0; i--) begin
			spi_sck = 1'b0;
			spi_di  = b[i];
			repeat (4) step();
			spi_sck = 1'b1;
			repeat (4) step();
		end
	endtask

	task automatic host_transfer(input logic [7:0] cmd, input int data_bytes);
		logic [31:0] rnd;
		int          i;
		spi_ss = 1'b0;
		repeat (8) step();
		send_serial_byte(cmd);
		for (i = 0; i < data_bytes; i++) begin
			rnd         = $random(seed);
			osd_bits[i] = rnd[7:0];
			send_serial_byte(rnd[7:0]);
		end
		spi_sck = 1'b0;
		repeat (8) step();
		spi_ss = 1'b1;
		repeat (8) step();
		if (cmd == video_pkg::OSD_CMD_ENABLE)
			osd_on = 1'b1;
		if (cmd == video_pkg::OSD_CMD_DISABLE)
			osd_on = 1'b0;
	endtask

	// Wait for every predicted pixel, then a quiet window for extras
	task automatic compare_outputs();
		video_pkg::pixel_t got;
		video_pkg::pixel_t expected;
		while (got_q.size() < exp_q.size())
			step();
		repeat (16) step();
		if (got_q.size() != exp_q.size()) begin
			error_count++;
			$display("DUT gave %0d pixels where %0d were expected", got_q.size(),
				exp_q.size());
		end
		while (got_q.size() > 0 && exp_q.size() > 0) begin
			got      = got_q.pop_front();
			expected = exp_q.pop_front();
			check_value("vga_r", 8'(got.r), 8'(expected.r));
			check_value("vga_g", 8'(got.g), 8'(expected.g));
			check_value("vga_b", 8'(got.b), 8'(expected.b));
			check_value("vga_hs", 8'(got.hs), 8'(expected.hs));
			check_value("vga_vs", 8'(got.vs), 8'(expected.vs));
		end
		got_q.delete();
		exp_q.delete();
	endtask

	task automatic end_test(input string name);
		int errors;
		errors = error_count - test_start;
		tests_run++;
		if (errors != 0)
			tests_failed++;
		$display("Test %s finished with %0d errors", name, errors);
	endtask

	task automatic run_frames_test(input string name, input logic off,
			input video_pkg::scan_level_t lvl, input logic yp, input logic full);
		scandouble_off = off;
		scanlines      = lvl;
		ypbpr          = yp;
		ypbpr_full     = full;
		apply_reset();
		test_start = error_count;
		send_frames(1);
		compare_outputs();
		end_test(name);
	endtask

	initial begin
		reset          = 1'b1;
		ce_pix         = 1'b0;
		pix_in         = '0;
		scanlines      = video_pkg::scan_none;
		scandouble_off = 1'b0;
		ypbpr          = 1'b0;
		ypbpr_full     = 1'b0;
		spi_sck        = 1'b0;
		spi_ss         = 1'b1;
		spi_di         = 1'b0;
		error_count    = 0;
		tests_run      = 0;
		tests_failed   = 0;
		clear_model();

		// No strobe yet, so syncs idle high
		apply_reset();
		test_start = error_count;
		repeat (24) begin
			step();
			check_value("vga_ce", 8'(vga_ce), 8'h0);
			check_value("vga_hs", 8'(vga_hs), 8'h1);
			check_value("vga_vs", 8'(vga_vs), 8'h1);
		end
		end_test("reset_idle");

		run_frames_test("pass_through", 1'b1, video_pkg::scan_none, 1'b0, 1'b0);
		run_frames_test("line_doubling", 1'b0, video_pkg::scan_none, 1'b0, 1'b0);
		run_frames_test("scanlines_quarter", 1'b0, video_pkg::scan_quarter, 1'b0, 1'b0);
		run_frames_test("scanlines_half", 1'b0, video_pkg::scan_half, 1'b0, 1'b0);
		run_frames_test("scanlines_three_quarter", 1'b0, video_pkg::scan_three_quarter,
			1'b0, 1'b0);

		// Bitmap load and enable, one frame, then disable and one more
		scandouble_off = 1'b1;
		scanlines      = video_pkg::scan_none;
		apply_reset();
		test_start = error_count;
		host_transfer(video_pkg::OSD_CMD_WRITE, video_pkg::OSD_WIDTH);
		host_transfer(video_pkg::OSD_CMD_ENABLE, 0);
		send_frames(1);
		compare_outputs();
		host_transfer(video_pkg::OSD_CMD_DISABLE, 0);
		send_frames(1);
		compare_outputs();
		end_test("osd_overlay");

		run_frames_test("ypbpr_limited", 1'b0, video_pkg::scan_none, 1'b1, 1'b0);
		run_frames_test("ypbpr_full", 1'b1, video_pkg::scan_none, 1'b1, 1'b1);

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* compile.f */
+incdir+dv
logic/video_pkg.sv
logic/scan_doubler.sv
logic/scanline_dimmer.sv
logic/osd_overlay.sv
logic/ypbpr_encoder.sv
logic/video_mixer.sv
dv/video_mixer_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module video_mixer_tb -Mdir obj_dir -o video_mixer_tb

run: compile
	./obj_dir/video_mixer_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
